//--- filelist.f
+incdir+common
common/pci_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
hdl/cmd_ctrl.sv
hdl/bus_mem.sv
hdl/pci_top.sv
dv/pci_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the harness testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module pci_tb \
  -o pci_tb_sim > build.log 2>&1 &&
./obj_dir/pci_tb_sim > sim.log 2>&1 ||
{ echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- dv/pci_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "pci_consts.svh"

module pci_tb;

  localparam int FRAME_CYCLES = 10 * `PCI_CLK_DIV;
  // Roughly 200 host frames plus bus traffic and reply gaps
  localparam int MAX_CYCLES   = 240 * FRAME_CYCLES + 2000;
  localparam int N_WORDS      = 8;
  localparam int N_DATA       = 4;
  localparam int ACK_WAIT     = 20;

  logic           sys_clk = 1'b0;
  logic           arst_n;
  logic           rx;
  logic           tx;
  logic           rst_core;
  logic           core_cyc;
  logic           core_stb;
  pci_pkg::word_t core_addr;
  pci_pkg::word_t core_data;
  logic           core_ack;
  logic           data_cyc;
  logic           data_stb;
  logic           data_we;
  pci_pkg::word_t data_addr;
  pci_pkg::word_t data_wdata;
  pci_pkg::word_t data_rdata;
  logic           data_ack;

  pci_pkg::word_t ref_mem [`PCI_MEM_WORDS];  // Expected memory content
  pci_pkg::word_t load_addr [N_WORDS];
  pci_pkg::word_t core_wr_addr [N_DATA];
  pci_pkg::byte_t reply_q [$];               // Bytes decoded from tx
  logic [31:0]    lfsr = 32'h34a7_7ca0;
  int             check_errors = 0;
  int             assert_errors = 0;
  int             cycles;

  always #5 sys_clk = ~sys_clk;

  pci_top pci_top_i (
    .sys_clk_i       (sys_clk),
    .arst_n_i        (arst_n),
    .rx_i            (rx),
    .tx_o            (tx),
    .rst_core_o      (rst_core),
    .core_cyc_i      (core_cyc),
    .core_stb_i      (core_stb),
    .core_addr_i     (core_addr),
    .core_data_o     (core_data),
    .core_ack_o      (core_ack),
    .data_mem_cyc_i  (data_cyc),
    .data_mem_stb_i  (data_stb),
    .data_mem_we_i   (data_we),
    .data_mem_addr_i (data_addr),
    .data_mem_data_i (data_wdata),
    .data_mem_data_o (data_rdata),
    .data_mem_ack_o  (data_ack)
  );

  task automatic count_assert_error(input string what);
    assert_errors++;
    $display("Assertion failed at %0t: %s", $time, what);
  endtask

  // Held core never sees an ack
  assert property (@(posedge sys_clk) disable iff (!arst_n)
      rst_core |-> !(core_ack || data_ack))
    else count_assert_error("ack while core reset is high");

  assert property (@(posedge sys_clk) disable iff (!arst_n)
      (core_cyc && core_stb && !rst_core && !core_ack) |=> core_ack)
    else count_assert_error("instruction ack not one cycle after request");

  assert property (@(posedge sys_clk) disable iff (!arst_n) core_ack |=> !core_ack)
    else count_assert_error("instruction ack longer than one cycle");

  assert property (@(posedge sys_clk) disable iff (!arst_n)
      (data_cyc && data_stb && !rst_core && !data_ack) |=> data_ack)
    else count_assert_error("data ack not one cycle after request");

  assert property (@(posedge sys_clk) disable iff (!arst_n) data_ack |=> !data_ack)
    else count_assert_error("data ack longer than one cycle");

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic pci_pkg::word_t rand_bits(input int n);
    pci_pkg::word_t v;
    logic           fb;
    int             i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input pci_pkg::word_t got,
                             input pci_pkg::word_t exp);
    assert (got === exp) else begin
      check_errors++;
      $display("FAIL %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic send_byte(input pci_pkg::byte_t b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};  // Stop, data LSB first, start
    for (i = 0; i < 10; i++) begin
      @(posedge sys_clk);
      #1 rx = frame[i];
      repeat (`PCI_CLK_DIV - 1) @(posedge sys_clk);
    end
  endtask

  task automatic send_word(input pci_pkg::word_t w);
    int k;
    for (k = 0; k < 4; k++) begin
      send_byte(w[8*k +: 8]);
    end
  endtask

  task automatic get_reply(output pci_pkg::byte_t b);
    int waited;
    waited = 0;
    while (reply_q.size() == 0 && waited < 3 * FRAME_CYCLES) begin
      @(negedge sys_clk);
      waited++;
    end
    if (reply_q.size() == 0) begin
      check_errors++;
      $display("No reply byte from the DUT in time");
      b = 8'h00;
    end else begin
      b = reply_q.pop_front();
    end
  endtask

  task automatic expect_reply(input string name, input pci_pkg::byte_t exp);
    pci_pkg::byte_t b;
    get_reply(b);
    check_value(name, 32'(b), 32'(exp));
  endtask

  task automatic host_write(input pci_pkg::word_t addr, input pci_pkg::word_t data);
    send_byte(8'h57);  // 'W'
    send_word(addr);
    send_word(data);
    expect_reply("write reply", 8'h4b);
  endtask

  // Reply bytes come least significant first
  task automatic host_read(input pci_pkg::word_t addr);
    pci_pkg::word_t exp;
    pci_pkg::byte_t b;
    int             k;
    exp = ref_mem[addr[9:2]];
    send_byte(8'h52);  // 'R'
    send_word(addr);
    for (k = 0; k < 4; k++) begin
      get_reply(b);
      check_value("read reply byte", 32'(b), 32'(exp[8*k +: 8]));
    end
  endtask

  // Counts negedges from the one where rx_valid is seen until rst_core_o reaches level
  task automatic check_reset_edge(input logic level, input int exp_n);
    int waited;
    int n;
    waited = 0;
    do begin
      @(negedge sys_clk);
      waited++;
    end while (!pci_top_i.rx_valid && waited < 2 * FRAME_CYCLES);
    if (!pci_top_i.rx_valid) begin
      check_errors++;
      $display("Command byte was never received by the DUT");
    end else begin
      n = 0;
      do begin
        @(negedge sys_clk);
        n++;
      end while (rst_core !== level && n <= exp_n + 4);
      check_value("rst_core_o edge cycle", 32'(n), 32'(exp_n));
      check_value("core_run", 32'(pci_top_i.core_run), 32'(!level));
    end
  endtask

  task automatic fetch(input pci_pkg::word_t addr, output pci_pkg::word_t data);
    int waited;
    @(posedge sys_clk);
    #1;
    core_cyc  = 1'b1;
    core_stb  = 1'b1;
    core_addr = addr;
    waited    = 0;
    do begin
      @(negedge sys_clk);
      waited++;
    end while (!core_ack && waited < ACK_WAIT);
    data = core_data;
    if (!core_ack) begin
      check_errors++;
      $display("No ack on the instruction bus");
    end
    @(posedge sys_clk);
    #1;
    core_cyc = 1'b0;
    core_stb = 1'b0;
  endtask

  task automatic data_access(input logic we, input pci_pkg::word_t addr,
                             input pci_pkg::word_t wdata, output pci_pkg::word_t rdata);
    int waited;
    @(posedge sys_clk);
    #1;
    data_cyc   = 1'b1;
    data_stb   = 1'b1;
    data_we    = we;
    data_addr  = addr;
    data_wdata = wdata;
    waited     = 0;
    do begin
      @(negedge sys_clk);
      waited++;
    end while (!data_ack && waited < ACK_WAIT);
    rdata = data_rdata;
    if (!data_ack) begin
      check_errors++;
      $display("No ack on the data bus");
    end
    @(posedge sys_clk);
    #1;
    data_cyc = 1'b0;
    data_stb = 1'b0;
    data_we  = 1'b0;
  endtask

  task automatic end_run(input logic timed_out);
    $display("Errors: %0d check, %0d assertion", check_errors, assert_errors);
    if (!timed_out && check_errors == 0 && assert_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // Decodes reply frames at bit centers
  initial begin : reply_monitor
    pci_pkg::byte_t b;
    int             i;
    b = 8'h00;
    forever begin
      @(negedge sys_clk);
      if (arst_n && !tx) begin
        repeat (`PCI_CLK_DIV / 2) @(negedge sys_clk);
        for (i = 0; i < 8; i++) begin
          repeat (`PCI_CLK_DIV) @(negedge sys_clk);
          b = {tx, b[7:1]};
        end
        repeat (`PCI_CLK_DIV) @(negedge sys_clk);
        if (!tx) begin
          check_errors++;
          $display("Reply frame has a low stop bit");
        end else begin
          reply_q.push_back(b);
        end
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge sys_clk);
      cycles++;
    end
    $display("Timeout, run did not end within %0d cycles", MAX_CYCLES);
    end_run(1'b1);
  end

  initial begin : main_seq
    pci_pkg::word_t a;
    pci_pkg::word_t d;
    pci_pkg::word_t got;
    int             k;
    arst_n     = 1'b0;
    rx         = 1'b1;
    core_cyc   = 1'b0;
    core_stb   = 1'b0;
    core_addr  = '0;
    data_cyc   = 1'b0;
    data_stb   = 1'b0;
    data_we    = 1'b0;
    data_addr  = '0;
    data_wdata = '0;
    repeat (5) @(posedge sys_clk);
    #1 arst_n = 1'b1;

    @(negedge sys_clk);
    check_value("tx_o", 32'(tx), 32'h1);
    check_value("rst_core_o", 32'(rst_core), 32'h1);
    check_value("core_ack_o", 32'(core_ack), 32'h0);
    check_value("data_mem_ack_o", 32'(data_ack), 32'h0);

    // Requests while halted, ack assertion watches them
    @(posedge sys_clk);
    #1;
    core_cyc = 1'b1;
    core_stb = 1'b1;
    data_cyc = 1'b1;
    data_stb = 1'b1;
    repeat (ACK_WAIT) @(posedge sys_clk);
    #1;
    core_cyc = 1'b0;
    core_stb = 1'b0;
    data_cyc = 1'b0;
    data_stb = 1'b0;

    send_byte(8'h50);  // 'P'
    expect_reply("ping reply", `PCI_ID);
    send_byte(8'h7a);  // Not a command
    expect_reply("unknown command reply", 8'h3f);

    for (k = 0; k < N_WORDS; k++) begin
      a = rand_bits(32);
      d = rand_bits(32);
      load_addr[k]    = a;
      ref_mem[a[9:2]] = d;
      host_write(a, d);
    end
    for (k = 0; k < N_WORDS; k++) begin
      host_read(load_addr[k]);
    end

    fork
      send_byte(8'h53);  // 'S'
      check_reset_edge(1'b0, `PCI_RESET_CYCLES + 1);
    join
    expect_reply("start reply", 8'h4b);

    for (k = 0; k < N_WORDS; k++) begin
      fetch(load_addr[k], got);
      check_value("core_data_o", got, ref_mem[load_addr[k][9:2]]);
    end

    for (k = 0; k < N_DATA; k++) begin
      a = rand_bits(32);
      d = rand_bits(32);
      core_wr_addr[k] = a;
      data_access(1'b1, a, d, got);
      ref_mem[a[9:2]] = d;
    end
    for (k = 0; k < N_DATA; k++) begin
      data_access(1'b0, core_wr_addr[k], '0, got);
      check_value("data_mem_data_o", got, ref_mem[core_wr_addr[k][9:2]]);
    end

    send_byte(8'h52);  // R refused while running
    expect_reply("read while running reply", 8'h3f);

    fork
      send_byte(8'h48);  // 'H'
      check_reset_edge(1'b1, 1);
    join
    expect_reply("halt reply", 8'h4b);

    for (k = 0; k < N_DATA; k++) begin
      host_read(core_wr_addr[k]);
    end

    end_run(1'b0);
  end

endmodule

`default_nettype wire

//--- hdl/pci_top.sv
`timescale 1ns/1ps
`default_nettype none

module pci_top (
  input  logic           sys_clk_i,
  input  logic           arst_n_i,
  input  logic           rx_i,
  output logic           tx_o,
  output logic           rst_core_o,
  input  logic           core_cyc_i,        // Instruction bus from the core
  input  logic           core_stb_i,
  input  pci_pkg::word_t core_addr_i,
  output pci_pkg::word_t core_data_o,
  output logic           core_ack_o,
  input  logic           data_mem_cyc_i,    // Data bus from the core
  input  logic           data_mem_stb_i,
  input  logic           data_mem_we_i,
  input  pci_pkg::word_t data_mem_addr_i,
  input  pci_pkg::word_t data_mem_data_i,
  output pci_pkg::word_t data_mem_data_o,
  output logic           data_mem_ack_o
);

  pci_pkg::byte_t    rx_byte;
  logic              rx_valid;
  pci_pkg::byte_t    tx_byte;
  logic              tx_start;
  logic              tx_busy;
  logic              ld_en;
  logic              ld_we;
  pci_pkg::mem_idx_t ld_idx;
  pci_pkg::word_t    ld_wdata;
  pci_pkg::word_t    ld_rdata;
  logic              core_run;

  uart_rx uart_rx_i (
    .sys_clk_i  (sys_clk_i),
    .arst_n_i   (arst_n_i),
    .rx_i       (rx_i),
    .rx_byte_o  (rx_byte),
    .rx_valid_o (rx_valid)
  );

  uart_tx uart_tx_i (
    .sys_clk_i  (sys_clk_i),
    .arst_n_i   (arst_n_i),
    .tx_byte_i  (tx_byte),
    .tx_start_i (tx_start),
    .tx_o       (tx_o),
    .tx_busy_o  (tx_busy)
  );

  cmd_ctrl cmd_ctrl_i (
    .sys_clk_i  (sys_clk_i),
    .arst_n_i   (arst_n_i),
    .rx_byte_i  (rx_byte),
    .rx_valid_i (rx_valid),
    .tx_byte_o  (tx_byte),
    .tx_start_o (tx_start),
    .tx_busy_i  (tx_busy),
    .ld_en_o    (ld_en),
    .ld_we_o    (ld_we),
    .ld_idx_o   (ld_idx),
    .ld_wdata_o (ld_wdata),
    .ld_rdata_i (ld_rdata),
    .core_run_o (core_run),
    .rst_core_o (rst_core_o)
  );

  // Shared memory, loader or instruction bus on A, data bus on B
  bus_mem bus_mem_i (
    .sys_clk_i    (sys_clk_i),
    .arst_n_i     (arst_n_i),
    .core_run_i   (core_run),
    .ld_en_i      (ld_en),
    .ld_we_i      (ld_we),
    .ld_idx_i     (ld_idx),
    .ld_wdata_i   (ld_wdata),
    .ld_rdata_o   (ld_rdata),
    .instr_cyc_i  (core_cyc_i),
    .instr_stb_i  (core_stb_i),
    .instr_addr_i (core_addr_i),
    .instr_data_o (core_data_o),
    .instr_ack_o  (core_ack_o),
    .data_cyc_i   (data_mem_cyc_i),
    .data_stb_i   (data_mem_stb_i),
    .data_we_i    (data_mem_we_i),
    .data_addr_i  (data_mem_addr_i),
    .data_data_i  (data_mem_data_i),
    .data_data_o  (data_mem_data_o),
    .data_ack_o   (data_mem_ack_o)
  );

endmodule

`default_nettype wire

//--- hdl/bus_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "pci_consts.svh"

module bus_mem (
  input  logic              sys_clk_i,
  input  logic              arst_n_i,
  input  logic              core_run_i,
  input  logic              ld_en_i,
  input  logic              ld_we_i,
  input  pci_pkg::mem_idx_t ld_idx_i,
  input  pci_pkg::word_t    ld_wdata_i,
  output pci_pkg::word_t    ld_rdata_o,
  input  logic              instr_cyc_i,
  input  logic              instr_stb_i,
  input  pci_pkg::word_t    instr_addr_i,
  output pci_pkg::word_t    instr_data_o,
  output logic              instr_ack_o,
  input  logic              data_cyc_i,
  input  logic              data_stb_i,
  input  logic              data_we_i,
  input  pci_pkg::word_t    data_addr_i,
  input  pci_pkg::word_t    data_data_i,
  output pci_pkg::word_t    data_data_o,
  output logic              data_ack_o
);

  pci_pkg::word_t    mem [`PCI_MEM_WORDS];
  pci_pkg::word_t    a_rdata;
  pci_pkg::word_t    b_rdata;
  pci_pkg::mem_idx_t a_idx;
  pci_pkg::mem_idx_t b_idx;
  logic              a_en;
  logic              a_we;
  logic              instr_req;
  logic              data_req;
  logic              instr_ack_q;
  logic              data_ack_q;

  // A request already in its ack cycle is not sampled again
  assign instr_req = core_run_i && instr_cyc_i && instr_stb_i && !instr_ack_q;
  assign data_req  = core_run_i && data_cyc_i && data_stb_i && !data_ack_q;

  // Port A belongs to the loader while the core is halted
  assign a_en  = core_run_i ? instr_req : ld_en_i;
  assign a_we  = !core_run_i && ld_we_i;   // Instruction port never writes
  assign a_idx = core_run_i ? instr_addr_i[9:2] : ld_idx_i;
  assign b_idx = data_addr_i[9:2];

  always_ff @(posedge sys_clk_i) begin
    if (a_en) begin
      if (a_we) begin
        mem[a_idx] <= ld_wdata_i;
      end
      a_rdata <= mem[a_idx];
    end
    if (data_req) begin
      if (data_we_i) begin
        mem[b_idx] <= data_data_i;   // Last write, port B wins a collision
      end
      b_rdata <= mem[b_idx];
    end
  end

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      instr_ack_q <= 1'b0;
      data_ack_q  <= 1'b0;
    end else begin
      instr_ack_q <= instr_req;      // One cycle pulse per request
      data_ack_q  <= data_req;
    end
  end

  assign ld_rdata_o   = a_rdata;
  assign instr_data_o = a_rdata;
  assign instr_ack_o  = instr_ack_q;
  assign data_data_o  = b_rdata;
  assign data_ack_o   = data_ack_q;

endmodule

`default_nettype wire

//--- hdl/cmd_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "pci_consts.svh"

module cmd_ctrl (
  input  logic              sys_clk_i,
  input  logic              arst_n_i,
  input  pci_pkg::byte_t    rx_byte_i,
  input  logic              rx_valid_i,
  output pci_pkg::byte_t    tx_byte_o,
  output logic              tx_start_o,
  input  logic              tx_busy_i,
  output logic              ld_en_o,
  output logic              ld_we_o,
  output pci_pkg::mem_idx_t ld_idx_o,
  output pci_pkg::word_t    ld_wdata_o,
  input  pci_pkg::word_t    ld_rdata_i,
  output logic              core_run_o,
  output logic              rst_core_o
);

  // Host command and reply characters
  localparam pci_pkg::byte_t CMD_WRITE = 8'h57;  // 'W'
  localparam pci_pkg::byte_t CMD_READ  = 8'h52;  // 'R'
  localparam pci_pkg::byte_t CMD_PING  = 8'h50;  // 'P'
  localparam pci_pkg::byte_t CMD_START = 8'h53;  // 'S'
  localparam pci_pkg::byte_t CMD_HALT  = 8'h48;  // 'H'
  localparam pci_pkg::byte_t REP_OK    = 8'h4b;  // 'K'
  localparam pci_pkg::byte_t REP_ERR   = 8'h3f;  // '?'

  localparam int RST_W = $clog2(`PCI_RESET_CYCLES + 1);
  localparam logic [RST_W-1:0] RST_LAST = RST_W'(`PCI_RESET_CYCLES - 1);

  pci_pkg::ctrl_state_e state;
  pci_pkg::byte_t       cmd;
  pci_pkg::byte_t       idle_reply;
  pci_pkg::word_t       addr;
  pci_pkg::word_t       data;
  pci_pkg::word_t       reply_word;
  logic [1:0]           byte_cnt;
  logic [2:0]           reply_left;    // Reply bytes still to send
  logic [RST_W-1:0]     stretch_cnt;
  logic                 send_now;

  // First reply byte chosen from the command byte
  always_comb begin
    case (rx_byte_i)
      CMD_PING:           idle_reply = `PCI_ID;
      CMD_START, CMD_HALT: idle_reply = REP_OK;
      default:            idle_reply = REP_ERR;  // Also W and R while running
    endcase
  end

  assign send_now = (state == pci_pkg::ST_SEND) && !tx_busy_i;

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state       <= pci_pkg::ST_IDLE;
      byte_cnt    <= '0;
      reply_left  <= '0;
      stretch_cnt <= '0;
      core_run_o  <= 1'b0;
      rst_core_o  <= 1'b1;
    end else begin
      case (state)
        pci_pkg::ST_IDLE: begin
          if (rx_valid_i) begin
            reply_left <= 3'd1;
            byte_cnt   <= '0;
            case (rx_byte_i)
              CMD_WRITE, CMD_READ: begin
                state <= core_run_o ? pci_pkg::ST_SEND : pci_pkg::ST_GET_ADDR;
              end
              CMD_START: begin
                core_run_o  <= 1'b0;     // Restart holds reset again
                rst_core_o  <= 1'b1;
                stretch_cnt <= RST_LAST;
                state       <= pci_pkg::ST_STRETCH;
              end
              CMD_HALT: begin
                core_run_o <= 1'b0;
                rst_core_o <= 1'b1;
                state      <= pci_pkg::ST_SEND;
              end
              default: state <= pci_pkg::ST_SEND;
            endcase
          end
        end
        pci_pkg::ST_GET_ADDR: begin
          if (rx_valid_i) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
              state <= (cmd == CMD_WRITE) ? pci_pkg::ST_GET_DATA : pci_pkg::ST_READ;
            end
          end
        end
        pci_pkg::ST_GET_DATA: begin
          if (rx_valid_i) begin
            byte_cnt <= byte_cnt + 1'b1;
            if (byte_cnt == 2'd3) begin
              state <= pci_pkg::ST_WRITE;
            end
          end
        end
        pci_pkg::ST_WRITE: state <= pci_pkg::ST_SEND;  // One 'K' byte
        pci_pkg::ST_READ:  state <= pci_pkg::ST_REPLY;
        pci_pkg::ST_REPLY: begin
          reply_left <= 3'd4;                          // Whole word back
          state      <= pci_pkg::ST_SEND;
        end
        pci_pkg::ST_SEND: begin
          if (send_now) begin
            reply_left <= reply_left - 1'b1;
            if (reply_left == 3'd1) begin
              state <= pci_pkg::ST_IDLE;
            end
          end
        end
        pci_pkg::ST_STRETCH: begin
          if (stretch_cnt == '0) begin
            core_run_o <= 1'b1;
            rst_core_o <= 1'b0;
            reply_left <= 3'd1;
            state      <= pci_pkg::ST_SEND;
          end else begin
            stretch_cnt <= stretch_cnt - 1'b1;
          end
        end
        default: state <= pci_pkg::ST_IDLE;
      endcase
    end
  end

  // Command, address, data and reply byte shifters
  always_ff @(posedge sys_clk_i) begin
    if (state == pci_pkg::ST_IDLE && rx_valid_i) begin
      cmd        <= rx_byte_i;
      reply_word <= {24'h0, idle_reply};
    end
    if (state == pci_pkg::ST_GET_ADDR && rx_valid_i) begin
      addr <= {rx_byte_i, addr[31:8]};   // LSB first
    end
    if (state == pci_pkg::ST_GET_DATA && rx_valid_i) begin
      data <= {rx_byte_i, data[31:8]};
    end
    if (state == pci_pkg::ST_WRITE) begin
      reply_word <= {24'h0, REP_OK};
    end
    if (state == pci_pkg::ST_REPLY) begin
      reply_word <= ld_rdata_i;
    end
    if (state == pci_pkg::ST_STRETCH && stretch_cnt == '0) begin
      reply_word <= {24'h0, REP_OK};
    end
    if (send_now) begin
      reply_word <= {8'h00, reply_word[31:8]};
    end
  end

  assign tx_byte_o  = reply_word[7:0];
  assign tx_start_o = send_now;

  assign ld_en_o    = (state == pci_pkg::ST_WRITE) || (state == pci_pkg::ST_READ);
  assign ld_we_o    = (state == pci_pkg::ST_WRITE);
  assign ld_idx_o   = addr[9:2];      // Byte address to word index
  assign ld_wdata_o = data;

endmodule

`default_nettype wire

//--- uart/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none
`include "pci_consts.svh"

module uart_tx (
  input  logic           sys_clk_i,
  input  logic           arst_n_i,
  input  pci_pkg::byte_t tx_byte_i,
  input  logic           tx_start_i,
  output logic           tx_o,
  output logic           tx_busy_o
);

  localparam int CNT_W = $clog2(`PCI_CLK_DIV);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`PCI_CLK_DIV - 1);
  localparam logic [3:0] STOP_IDX = 4'd9;

  logic [9:0]       shreg;     // Stop, 8 data bits, start
  logic             busy;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      shreg    <= '1;            // Line idles high
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end else if (!busy) begin
      if (tx_start_i) begin
        shreg    <= {1'b1, tx_byte_i, 1'b0};
        busy     <= 1'b1;
        baud_cnt <= FULL_BIT;
        bit_idx  <= '0;
      end
    end else if (baud_cnt != '0) begin
      baud_cnt <= baud_cnt - 1'b1;
    end else begin
      // Bit period over, shift in idle ones behind the frame
      baud_cnt <= FULL_BIT;
      shreg    <= {1'b1, shreg[9:1]};
      bit_idx  <= bit_idx + 1'b1;
      if (bit_idx == STOP_IDX) begin
        busy <= 1'b0;            // Stop bit fully sent
      end
    end
  end

  assign tx_o      = shreg[0];
  assign tx_busy_o = busy;

endmodule

`default_nettype wire

//--- uart/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none
`include "pci_consts.svh"

module uart_rx (
  input  logic           sys_clk_i,
  input  logic           arst_n_i,
  input  logic           rx_i,
  output pci_pkg::byte_t rx_byte_o,
  output logic           rx_valid_o
);

  localparam int CNT_W = $clog2(`PCI_CLK_DIV);
  localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(`PCI_CLK_DIV - 1);
  localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(`PCI_CLK_DIV / 2 - 1);
  localparam logic [3:0] STOP_IDX = 4'd9;

  logic             rx_meta;
  logic             rx_sync;
  logic             busy;
  logic             bit_tick;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;   // 0 start, 1..8 data, 9 stop
  pci_pkg::byte_t   shreg;

  // Two flop synchronizer, idles high like the line
  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
    end
  end

  assign bit_tick = (baud_cnt == '0);

  always_ff @(posedge sys_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy       <= 1'b0;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= 1'b0;
      if (!busy) begin
        if (!rx_sync) begin         // Falling edge of start bit
          busy     <= 1'b1;
          baud_cnt <= HALF_BIT;      // First sample lands mid start bit
          bit_idx  <= '0;
        end
      end else if (!bit_tick) begin
        baud_cnt <= baud_cnt - 1'b1;
      end else begin
        baud_cnt <= FULL_BIT;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == 4'd0 && rx_sync) begin
          busy <= 1'b0;              // Glitch, not a real start bit
        end else if (bit_idx == STOP_IDX) begin
          busy       <= 1'b0;
          rx_valid_o <= rx_sync;     // Low stop bit drops the frame
        end
      end
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge sys_clk_i) begin
    if (busy && bit_tick && bit_idx >= 4'd1 && bit_idx <= 4'd8) begin
      shreg <= {rx_sync, shreg[7:1]};
    end
  end

  assign rx_byte_o = shreg;

endmodule

`default_nettype wire

//--- common/pci_pkg.sv
`default_nettype none

package pci_pkg;

  // One UART payload byte
  typedef logic [7:0] byte_t;

  // Bus address or data word
  typedef logic [31:0] word_t;

  // Word index into the shared memory
  typedef logic [7:0] mem_idx_t;

  // Command sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,      // Waiting for a command byte
    ST_GET_ADDR,  // Collecting 4 address bytes
    ST_GET_DATA,  // Collecting 4 data bytes
    ST_WRITE,     // Loader write strobe
    ST_READ,      // Loader read strobe
    ST_REPLY,     // Capture of loader read data
    ST_SEND,      // Feeding reply bytes to the transmitter
    ST_STRETCH    // Core reset held after a start
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- common/pci_consts.svh
`ifndef PCI_CONSTS_SVH
`define PCI_CONSTS_SVH

// UART bit period in sys_clk cycles
// A full frame of 10 bits takes ten of these
`define PCI_CLK_DIV 16

// Shared word memory depth
// Word index comes from byte address bits 9 down to 2
`define PCI_MEM_WORDS 256

// Identifier byte returned by the ping command
`define PCI_ID 8'h5a

// Core reset hold time after a start command, in sys_clk cycles
`define PCI_RESET_CYCLES 4

`endif
